// File: filelist.f
nocPkg.sv
flitFifo.sv
lbdrRoute.sv
switchAlloc.sv
flitCrossbar.sv
nocRouter.sv
routerTb.sv

// File: routerTb.sv
/* Router testbench with a packet table applied in waves, expected output ports
   from the LBDR rule, per-output packet checking and a cycle timeout */

module routerTb;

  localparam int np = nocPkg::numPorts;
  localparam int numRows = 23;
  localparam int numWaves = 13;
  localparam int maxLen = 16;
  localparam int maxStream = 16;

  // Router configuration shared by both instances apart from the links
  localparam logic [7:0] routeBits = 8'd60;
  localparam logic [3:0] connBits = 4'd15;
  // East link cut on the second router
  localparam logic [3:0] connBitsNoEast = 4'b1101;
  localparam logic [3:0] curAddr = 4'd5;

  // One packet per row with the rows of one wave injected together
  typedef struct packed {
    logic [3:0] wave;
    logic       dut;
    logic [2:0] inPort;
    logic [3:0] dst;
    logic [3:0] len;
    logic [7:0] seed;
  } pktRowT;

  logic clk;
  logic rst;

  nocPkg::flitT  inFlitA [np];
  logic [np-1:0] inValidA;
  nocPkg::flitT  outFlitA [np];
  logic [np-1:0] outValidA;

  nocPkg::flitT  inFlitB [np];
  logic [np-1:0] inValidB;
  nocPkg::flitT  outFlitB [np];
  logic [np-1:0] outValidB;

  pktRowT      pktTable [numRows];
  logic [15:0] pktFlits [numRows][maxLen];
  logic        pending [numRows];
  // Expected output numbered as dut * np + port
  int          expQ [numRows];

  // Packet being received on each output or -1 when idle
  int curPkt [2*np];
  int curIdx [2*np];
  int outstanding;

  // Flits queued per input for the current wave
  logic [15:0] streamFlit [2][np][maxStream];
  int          streamLen [2][np];

  int     cycleCount;
  int     timeoutLimit;
  integer seed;

  nocRouter #(
    .routeBits (routeBits),
    .connBits  (connBits),
    .curAddr   (curAddr),
    .fifoDepth (8)
  ) u_nocRouter (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlitA),
    .inValid  (inValidA),
    .outFlit  (outFlitA),
    .outValid (outValidA)
  );

  nocRouter #(
    .routeBits (routeBits),
    .connBits  (connBitsNoEast),
    .curAddr   (curAddr),
    .fifoDepth (8)
  ) u_nocRouterNoEast (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlitB),
    .inValid  (inValidB),
    .outFlit  (outFlitB),
    .outValid (outValidB)
  );

  always #50 clk = ~clk;

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  // Output port by quadrant of the destination or -1 if no link is allowed
  function automatic int expectedPort(input logic [3:0] dst, input logic [3:0] conn);
    logic north;
    logic south;
    logic east;
    logic west;
    logic [np-1:0] req;
    north = dst[3:2] < curAddr[3:2];
    south = dst[3:2] > curAddr[3:2];
    east  = dst[1:0] > curAddr[1:0];
    west  = dst[1:0] < curAddr[1:0];
    req = '0;
    if (!north && !south && !east && !west) begin
      req[nocPkg::portL] = 1'b1;
    end else if (!east && !west) begin
      // Same column
      req[nocPkg::portN] = north & conn[0];
      req[nocPkg::portS] = south & conn[3];
    end else if (!north && !south) begin
      // Same row
      req[nocPkg::portE] = east & conn[1];
      req[nocPkg::portW] = west & conn[2];
    end else if (north && east) begin
      req[nocPkg::portN] = routeBits[0] & conn[0];
      req[nocPkg::portE] = routeBits[2] & conn[1];
    end else if (north && west) begin
      req[nocPkg::portN] = routeBits[1] & conn[0];
      req[nocPkg::portW] = routeBits[4] & conn[2];
    end else if (south && east) begin
      req[nocPkg::portE] = routeBits[3] & conn[1];
      req[nocPkg::portS] = routeBits[6] & conn[3];
    end else begin
      req[nocPkg::portW] = routeBits[5] & conn[2];
      req[nocPkg::portS] = routeBits[7] & conn[3];
    end
    for (int p = 0; p < np; p++) begin
      if (req[p]) begin
        return p;
      end
    end
    return -1;
  endfunction

  // Header tagged with the row and random payload in body and tail
  task automatic buildPacket(input int r);
    nocPkg::flitT f;
    f = '0;
    seed = 32'h7633 + int'(pktTable[r].seed);
    f.headerView.flitId  = nocPkg::flitIdHeader;
    f.headerView.dstAddr = pktTable[r].dst;
    f.headerView.srcAddr = 4'(pktTable[r].inPort);
    f.headerView.spare   = 5'(r);
    pktFlits[r][0] = f;
    for (int k = 1; k < int'(pktTable[r].len); k++) begin
      if (k == int'(pktTable[r].len) - 1) begin
        f.bodyView.flitId = nocPkg::flitIdTail;
      end else begin
        f.bodyView.flitId = nocPkg::flitIdBody;
      end
      f.bodyView.data = 13'($random(seed));
      pktFlits[r][k] = f;
    end
  endtask

  // Compare one output flit against the packet open on that output
  task automatic checkFlit(input int q, input logic [15:0] got);
    int row;
    logic [15:0] want;
    string dutName;
    string name;
    row = -1;
    if (q < np) begin
      dutName = "u_nocRouter";
    end else begin
      dutName = "u_nocRouterNoEast";
    end
    name = $sformatf("%s.outFlit[%0d]", dutName, q % np);
    if (curPkt[q] < 0) begin
      // Header must open a packet still expected on this output
      for (int r = 0; r < numRows; r++) begin
        if (row < 0 && pending[r] && expQ[r] == q && pktFlits[r][0] === got) begin
          row = r;
        end
      end
      assert (row >= 0) else failRun($sformatf(
        "error at time %0t: %s carried %h, which opens no packet expected there",
        $time, name, got));
      curPkt[q] = row;
      curIdx[q] = 1;
    end else begin
      want = pktFlits[curPkt[q]][curIdx[q]];
      assert (got === want) else failRun($sformatf(
        "error at time %0t: %s expected %h got %h", $time, name, want, got));
      curIdx[q]++;
      if (curIdx[q] == int'(pktTable[curPkt[q]].len)) begin
        pending[curPkt[q]] = 1'b0;
        outstanding--;
        curPkt[q] = -1;
      end
    end
  endtask

  // Queue the wave's packets per input, drive them and wait for delivery
  task automatic runWave(input int w);
    int maxLenW;
    int port;
    int d;
    int p;
    maxLenW = 0;
    for (int i = 0; i < 2 * np; i++) begin
      streamLen[i / np][i % np] = 0;
    end
    for (int r = 0; r < numRows; r++) begin
      if (int'(pktTable[r].wave) == w) begin
        d = int'(pktTable[r].dut);
        p = int'(pktTable[r].inPort);
        port = expectedPort(pktTable[r].dst, d ? connBitsNoEast : connBits);
        // Dropped packets expect nothing
        if (port >= 0) begin
          expQ[r] = d * np + port;
          pending[r] = 1'b1;
          outstanding++;
        end
        for (int k = 0; k < int'(pktTable[r].len); k++) begin
          streamFlit[d][p][streamLen[d][p]] = pktFlits[r][k];
          streamLen[d][p]++;
        end
        if (streamLen[d][p] > maxLenW) begin
          maxLenW = streamLen[d][p];
        end
      end
    end
    for (int k = 0; k < maxLenW; k++) begin
      @(posedge clk);
      #10;
      for (int i = 0; i < np; i++) begin
        inValidA[i] = (k < streamLen[0][i]);
        inFlitA[i]  = (k < streamLen[0][i]) ? streamFlit[0][i][k] : 16'h0;
        inValidB[i] = (k < streamLen[1][i]);
        inFlitB[i]  = (k < streamLen[1][i]) ? streamFlit[1][i][k] : 16'h0;
      end
    end
    @(posedge clk);
    #10;
    inValidA = '0;
    inValidB = '0;
    while (outstanding != 0) begin
      @(posedge clk);
    end
  endtask

  // Outputs sampled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      for (int p = 0; p < np; p++) begin
        if (outValidA[p]) begin
          checkFlit(p, outFlitA[p]);
        end
        if (outValidB[p]) begin
          checkFlit(np + p, outFlitB[p]);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > timeoutLimit) begin
      failRun($sformatf("error: timeout at time %0t after %0d cycles, %0d packets missing",
        $time, cycleCount, outstanding));
    end
  end

  initial begin
    int totalFlits;
    clk = 1'b0;
    rst = 1'b1;
    inValidA = '0;
    inValidB = '0;
    for (int p = 0; p < np; p++) begin
      inFlitA[p] = '0;
      inFlitB[p] = '0;
    end
    for (int q = 0; q < 2 * np; q++) begin
      curPkt[q] = -1;
      curIdx[q] = 0;
    end
    outstanding = 0;
    cycleCount = 0;
    pktTable = '{
      // wave, dut, input, destination, length, seed
      '{4'd0, 1'b0, 3'(nocPkg::portL), 4'd1, 4'd3, 8'd1},
      '{4'd1, 1'b0, 3'(nocPkg::portL), 4'd6, 4'd4, 8'd2},
      '{4'd2, 1'b0, 3'(nocPkg::portL), 4'd4, 4'd2, 8'd3},
      '{4'd3, 1'b0, 3'(nocPkg::portL), 4'd9, 4'd5, 8'd4},
      '{4'd4, 1'b0, 3'(nocPkg::portN), 4'd5, 4'd3, 8'd5},
      // Diagonals NE, NW, SE, SW
      '{4'd5, 1'b0, 3'(nocPkg::portL), 4'd2, 4'd3, 8'd6},
      '{4'd6, 1'b0, 3'(nocPkg::portE), 4'd0, 4'd3, 8'd7},
      '{4'd7, 1'b0, 3'(nocPkg::portS), 4'd10, 4'd2, 8'd8},
      '{4'd8, 1'b0, 3'(nocPkg::portN), 4'd12, 4'd3, 8'd9},
      // East-bound drop followed by traffic behind it
      '{4'd9, 1'b1, 3'(nocPkg::portL), 4'd7, 4'd3, 8'd10},
      '{4'd9, 1'b1, 3'(nocPkg::portL), 4'd13, 4'd3, 8'd11},
      '{4'd9, 1'b1, 3'(nocPkg::portW), 4'd1, 4'd2, 8'd12},
      // Two inputs fight for North
      '{4'd10, 1'b0, 3'(nocPkg::portE), 4'd1, 4'd6, 8'd13},
      '{4'd10, 1'b0, 3'(nocPkg::portW), 4'd1, 4'd6, 8'd14},
      // All outputs busy at once
      '{4'd11, 1'b0, 3'(nocPkg::portN), 4'd9, 4'd4, 8'd15},
      '{4'd11, 1'b0, 3'(nocPkg::portE), 4'd4, 4'd4, 8'd16},
      '{4'd11, 1'b0, 3'(nocPkg::portW), 4'd6, 4'd4, 8'd17},
      '{4'd11, 1'b0, 3'(nocPkg::portS), 4'd1, 4'd4, 8'd18},
      '{4'd11, 1'b0, 3'(nocPkg::portL), 4'd5, 4'd4, 8'd19},
      // Three-way contention on Local
      '{4'd12, 1'b0, 3'(nocPkg::portN), 4'd5, 4'd3, 8'd20},
      '{4'd12, 1'b0, 3'(nocPkg::portE), 4'd5, 4'd3, 8'd21},
      '{4'd12, 1'b0, 3'(nocPkg::portS), 4'd5, 4'd3, 8'd22},
      '{4'd12, 1'b0, 3'(nocPkg::portL), 4'd13, 4'd2, 8'd23}
    };
    totalFlits = 0;
    for (int r = 0; r < numRows; r++) begin
      pending[r] = 1'b0;
      expQ[r] = -1;
      buildPacket(r);
      totalFlits += int'(pktTable[r].len);
    end
    timeoutLimit = totalFlits * 20 + 200;
    repeat (10) @(posedge clk);
    #10;
    rst = 1'b0;
    for (int w = 0; w < numWaves; w++) begin
      runWave(w);
    end
    // Quiet window so a stray flit still gets caught
    repeat (10) @(posedge clk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: nocRouter.sv
/* Five-port mesh wormhole router: input FIFOs, LBDR route blocks,
   round-robin switch allocator and registered crossbar */

module nocRouter #(
  parameter logic [7:0] routeBits = 8'd60,
  parameter logic [3:0] connBits  = 4'd15,
  parameter logic [nocPkg::meshAddrWidth-1:0] curAddr = 4'd5,
  parameter int fifoDepth = 8
) (
  input  logic                         clk,
  input  logic                         rst,
  input  nocPkg::flitT                 inFlit [nocPkg::numPorts],
  input  logic [nocPkg::numPorts-1:0]  inValid,
  output nocPkg::flitT                 outFlit [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0]  outValid
);

  localparam int np = nocPkg::numPorts;

  // FIFO head of each input
  nocPkg::flitT headFlit [np];
  logic [np-1:0] empty;

  // Held output request of each input
  nocPkg::portVecT routeReq [np];

  // Allocator to FIFOs and crossbar
  logic [np-1:0] pop;
  logic [2:0]    selIn [np];
  logic [np-1:0] fwd;

  // One FIFO and route block per input port
  for (genvar i = 0; i < np; i++) begin : gInput

    flitFifo #(
      .fifoDepth (fifoDepth)
    ) u_flitFifo (
      .clk      (clk),
      .rst      (rst),
      .wrFlit   (inFlit[i]),
      .wrEn     (inValid[i]),
      .pop      (pop[i]),
      .headFlit (headFlit[i]),
      .empty    (empty[i])
    );

    // All route blocks share the router's own address and bits
    lbdrRoute #(
      .routeBits (routeBits),
      .connBits  (connBits),
      .curAddr   (curAddr)
    ) u_lbdrRoute (
      .clk      (clk),
      .rst      (rst),
      .headFlit (headFlit[i]),
      .empty    (empty[i]),
      .pop      (pop[i]),
      .routeReq (routeReq[i])
    );

  end

  // Output arbitration and packet locks
  switchAlloc u_switchAlloc (
    .clk      (clk),
    .rst      (rst),
    .routeReq (routeReq),
    .headFlit (headFlit),
    .empty    (empty),
    .pop      (pop),
    .selIn    (selIn),
    .fwd      (fwd)
  );

  // Flit transfer to the output registers
  flitCrossbar u_flitCrossbar (
    .clk      (clk),
    .rst      (rst),
    .headFlit (headFlit),
    .selIn    (selIn),
    .fwd      (fwd),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

// File: flitCrossbar.sv
/* Registered five-by-five flit crossbar, one output register
   per port loaded from the input chosen by the allocator */

module flitCrossbar (
  input  logic                         clk,
  input  logic                         rst,
  input  nocPkg::flitT                 headFlit [nocPkg::numPorts],
  input  logic [2:0]                   selIn [nocPkg::numPorts],
  input  logic [nocPkg::numPorts-1:0]  fwd,
  output nocPkg::flitT                 outFlit [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0]  outValid
);

  localparam int np = nocPkg::numPorts;

  // Selected source flit per output
  nocPkg::flitT muxFlit [np];

  // Input mux per output
  always_comb begin
    for (int o = 0; o < np; o++) begin
      muxFlit[o] = headFlit[selIn[o]];
    end
  end

  // Output data registers
  // Load only on a forwarded flit, hold otherwise
  always_ff @(posedge clk) begin
    for (int o = 0; o < np; o++) begin
      if (fwd[o]) begin
        outFlit[o] <= muxFlit[o];
      end
    end
  end

  // Output strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= '0;
    end else begin
      outValid <= fwd;
    end
  end

endmodule

// File: switchAlloc.sv
/* Switch allocator: per-output round-robin grant with a wormhole
   lock from header to tail, pop strobes and crossbar selects */

module switchAlloc (
  input  logic                         clk,
  input  logic                         rst,
  input  nocPkg::portVecT              routeReq [nocPkg::numPorts],
  input  nocPkg::flitT                 headFlit [nocPkg::numPorts],
  input  logic [nocPkg::numPorts-1:0]  empty,
  output logic [nocPkg::numPorts-1:0]  pop,
  output logic [2:0]                   selIn [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0]  fwd
);

  localparam int np = nocPkg::numPorts;

  // Per output state
  logic [np-1:0] lock;
  logic [2:0]    owner [np];
  logic [2:0]    rrPtr [np];

  // Per input, set while the route block holds a packet
  logic [np-1:0] routeDone;

  logic [np-1:0] isHeader;
  logic [np-1:0] isTail;
  logic [np-1:0] drain;
  logic [np-1:0] grantValid;
  logic [2:0]    grantIdx [np];

  // Head flit decode and drop detection per input
  always_comb begin
    for (int i = 0; i < np; i++) begin
      isHeader[i] = (headFlit[i].headerView.flitId == nocPkg::flitIdHeader);
      isTail[i]   = (headFlit[i].bodyView.flitId == nocPkg::flitIdTail);
      // Routed to nowhere, or a stray flit with no header in front
      drain[i] = !empty[i] && (routeReq[i] == '0) && (routeDone[i] || !isHeader[i]);
    end
  end

  // Round-robin search on each free output
  // Search starts one past the last winner
  always_comb begin
    int idx;
    idx = 0;
    for (int o = 0; o < np; o++) begin
      grantValid[o] = 1'b0;
      grantIdx[o]   = '0;
      for (int k = 1; k <= np; k++) begin
        idx = (int'(rrPtr[o]) + k) % np;
        if (!grantValid[o] && !lock[o] && !empty[idx] && isHeader[idx] &&
            routeReq[idx][o]) begin
          grantValid[o] = 1'b1;
          grantIdx[o]   = 3'(idx);
        end
      end
    end
  end

  // Locked outputs move one flit per cycle from their owner
  always_comb begin
    pop = drain;
    for (int o = 0; o < np; o++) begin
      selIn[o] = owner[o];
      fwd[o]   = lock[o] && !empty[owner[o]];
      if (fwd[o]) begin
        pop[owner[o]] = 1'b1;
      end
    end
  end

  // Lock, owner and pointer update
  always_ff @(posedge clk) begin
    if (rst) begin
      lock <= '0;
      for (int o = 0; o < np; o++) begin
        owner[o] <= '0;
        // First search begins at input 0
        rrPtr[o] <= 3'(np - 1);
      end
    end else begin
      for (int o = 0; o < np; o++) begin
        if (grantValid[o]) begin
          lock[o]  <= 1'b1;
          owner[o] <= grantIdx[o];
          rrPtr[o] <= grantIdx[o];
        end else if (fwd[o] && isTail[owner[o]]) begin
          // Release once the tail is on its way
          lock[o] <= 1'b0;
        end
      end
    end
  end

  // Tracks the route block state so an unrouted header is not drained
  always_ff @(posedge clk) begin
    if (rst) begin
      routeDone <= '0;
    end else begin
      for (int i = 0; i < np; i++) begin
        if (pop[i] && isTail[i]) begin
          routeDone[i] <= 1'b0;
        end else if (!routeDone[i] && !empty[i] && isHeader[i]) begin
          routeDone[i] <= 1'b1;
        end
      end
    end
  end

endmodule

// File: lbdrRoute.sv
/* Minimal LBDR output port selection for one input port,
   evaluated on the header flit and held until the tail leaves */

module lbdrRoute #(
  parameter logic [7:0] routeBits = 8'd60,
  parameter logic [3:0] connBits  = 4'd15,
  parameter logic [nocPkg::meshAddrWidth-1:0] curAddr = 4'd5
) (
  input  logic            clk,
  input  logic            rst,
  input  nocPkg::flitT    headFlit,
  input  logic            empty,
  input  logic            pop,
  output nocPkg::portVecT routeReq
);

  // Routing bits, two per mesh direction
  localparam logic rne = routeBits[0];
  localparam logic rnw = routeBits[1];
  localparam logic ren = routeBits[2];
  localparam logic res = routeBits[3];
  localparam logic rwn = routeBits[4];
  localparam logic rws = routeBits[5];
  localparam logic rse = routeBits[6];
  localparam logic rsw = routeBits[7];

  // Connectivity bits, one per mesh output
  localparam logic cn = connBits[0];
  localparam logic ce = connBits[1];
  localparam logic cw = connBits[2];
  localparam logic cs = connBits[3];

  // Own coordinates
  localparam logic [1:0] xCur = curAddr[1:0];
  localparam logic [1:0] yCur = curAddr[3:2];

  logic [1:0] xDst;
  logic [1:0] yDst;
  logic n1, e1, w1, s1;
  logic isHeader;
  logic isTail;
  logic active;
  nocPkg::portVecT portNext;

  assign xDst = headFlit.headerView.dstAddr[1:0];
  assign yDst = headFlit.headerView.dstAddr[3:2];

  assign isHeader = (headFlit.headerView.flitId == nocPkg::flitIdHeader);
  assign isTail   = (headFlit.bodyView.flitId == nocPkg::flitIdTail);

  // Quadrant of the destination relative to this router
  assign n1 = yDst < yCur;
  assign e1 = xCur < xDst;
  assign w1 = xDst < xCur;
  assign s1 = yCur < yDst;

  // One request per direction, straight or turning by the routing bits
  always_comb begin
    portNext = '0;
    portNext[nocPkg::portN] = ((n1 & ~e1 & ~w1) | (n1 & e1 & rne) | (n1 & w1 & rnw)) & cn;
    portNext[nocPkg::portE] = ((e1 & ~n1 & ~s1) | (e1 & n1 & ren) | (e1 & s1 & res)) & ce;
    portNext[nocPkg::portW] = ((w1 & ~n1 & ~s1) | (w1 & n1 & rwn) | (w1 & s1 & rws)) & cw;
    portNext[nocPkg::portS] = ((s1 & ~e1 & ~w1) | (s1 & e1 & rse) | (s1 & w1 & rsw)) & cs;
    // Arrived when no direction is left
    portNext[nocPkg::portL] = ~n1 & ~e1 & ~w1 & ~s1;
  end

  // Route register, owned by one packet from header to tail
  // A zero result still marks the block active so the packet drains
  always_ff @(posedge clk) begin
    if (rst) begin
      active   <= 1'b0;
      routeReq <= '0;
    end else if (active && pop && isTail) begin
      active   <= 1'b0;
      routeReq <= '0;
    end else if (!active && !empty && isHeader) begin
      active   <= 1'b1;
      routeReq <= portNext;
    end
  end

endmodule

// File: flitFifo.sv
/* Input port flit FIFO: circular buffer with occupancy count,
   head-of-queue view and pop strobe */

module flitFifo #(
  parameter int fifoDepth = 8
) (
  input  logic         clk,
  input  logic         rst,
  input  nocPkg::flitT wrFlit,
  input  logic         wrEn,
  input  logic         pop,
  output nocPkg::flitT headFlit,
  output logic         empty
);

  localparam int ptrWidth = $clog2(fifoDepth);

  // Flit storage
  nocPkg::flitT mem [fifoDepth];

  // Pointers wrap on their own since the depth is a power of two
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth:0]   count;

  logic full;
  logic doWrite;
  logic doRead;

  assign full  = (count == (ptrWidth + 1)'(fifoDepth));
  assign empty = (count == '0);

  // Write to a full buffer and pop from an empty one are dropped
  assign doWrite = wrEn && !full;
  assign doRead  = pop && !empty;

  // Oldest flit, valid whenever the buffer is not empty
  assign headFlit = mem[rdPtr];

  // Storage array
  always_ff @(posedge clk) begin
    if (doWrite) begin
      mem[wrPtr] <= wrFlit;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doWrite) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doRead) begin
        rdPtr <= rdPtr + 1'b1;
      end
      // Simultaneous write and read leaves the count unchanged
      if (doWrite && !doRead) begin
        count <= count + 1'b1;
      end else if (doRead && !doWrite) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: nocPkg.sv
/* Shared mesh NoC definitions: port indices, flit type codes,
   mesh address fields, the flit word union and the output port vector */

package nocPkg;

  // Router ports
  localparam int numPorts = 5;

  // Port index of each direction
  // The bit positions in a port vector follow the same order
  localparam int portN = 0;
  localparam int portE = 1;
  localparam int portW = 2;
  localparam int portS = 3;
  localparam int portL = 4;

  // Flit word width
  localparam int flitWidth = 16;

  // Flit type field, always in the top bits of the word
  localparam int flitIdWidth = 3;

  // Flit type codes, one-hot
  localparam logic [flitIdWidth-1:0] flitIdHeader = 3'b001;
  localparam logic [flitIdWidth-1:0] flitIdBody   = 3'b010;
  localparam logic [flitIdWidth-1:0] flitIdTail   = 3'b100;

  // Mesh address, y in the upper half and x in the lower half
  localparam int meshAddrWidth = 4;

  // Leftover bits in a header after the type and two addresses
  localparam int hdrSpareWidth = flitWidth - flitIdWidth - 2 * meshAddrWidth;

  // Payload bits in a body or tail flit
  localparam int bodyDataWidth = flitWidth - flitIdWidth;

  // One flit word, seen as a header or as a body/tail flit
  typedef union packed {
    struct packed {
      logic [flitIdWidth-1:0]   flitId;
      logic [meshAddrWidth-1:0] dstAddr;
      logic [meshAddrWidth-1:0] srcAddr;
      logic [hdrSpareWidth-1:0] spare;
    } headerView;
    struct packed {
      logic [flitIdWidth-1:0]   flitId;
      logic [bodyDataWidth-1:0] data;
    } bodyView;
  } flitT;

  // One-hot set of output ports, indexed by the port constants
  typedef logic [numPorts-1:0] portVecT;

endpackage
